// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_icache
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= All tests passed!

SOURCES := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# The run fails unless the pass message shows up in the simulator output.
run: $(SIM_BIN)
	@out="$$($(SIM_BIN) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
icache_geom_pkg.sv
icache_ctrl_pkg.sv
icache_fill_if.sv
icache_main_fsm.sv
icache_way_store.sv
icache_lru.sv
icache_refill.sv
icache_top.sv
tb_icache_assert.sv
tb_icache_checker.sv
tb_icache.sv

// ==== icache_ctrl_pkg.sv ====
package icache_ctrl_pkg;

    typedef logic [icache_geom_pkg::NUM_WAYS-1:0] way_oh_t;

    // Main controller states, in the order a miss walks through them.
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        LOOKUP  = 2'd1,
        REPLACE = 2'd2,
        REFILL  = 2'd3
    } ctrl_state_t;

    function automatic logic way_oh_any(way_oh_t w);
        return |w;
    endfunction

endpackage

// ==== icache_fill_if.sv ====
`timescale 1ns/1ps

interface icache_fill_if
    import icache_geom_pkg::*;
    ();

    // High for one cycle, on the edge where the last beat of a line arrives.
    logic   fill_done;
    line_t  fill_line;
    index_t fill_index;
    tag_t   fill_tag;

    modport source (
        output fill_done,
        output fill_line,
        output fill_index,
        output fill_tag
    );

    modport sink (
        input fill_done,
        input fill_line,
        input fill_index,
        input fill_tag
    );

    // The controller only needs to know when a fill completes.
    modport monitor (
        input fill_done
    );

endinterface

// ==== icache_geom_pkg.sv ====
package icache_geom_pkg;

    localparam int NUM_WAYS   = 4;
    localparam int NUM_SETS   = 64;
    localparam int LINE_WORDS = 4;
    localparam int WORD_BITS  = 32;

    typedef logic [31:0] addr_t;
    typedef logic [21:0] tag_t;
    typedef logic [5:0]  index_t;
    typedef logic [1:0]  word_sel_t;
    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [LINE_WORDS*WORD_BITS-1:0] line_t;

    // Byte address layout is tag [31:10], set index [9:4], word [3:2].
    function automatic tag_t addr_tag(addr_t a);
        return a[31:10];
    endfunction

    function automatic index_t addr_index(addr_t a);
        return a[9:4];
    endfunction

    function automatic word_sel_t addr_word(addr_t a);
        return a[3:2];
    endfunction

    function automatic word_t line_word(line_t l, word_sel_t s);
        return l[s*WORD_BITS +: WORD_BITS];
    endfunction

endpackage

// ==== icache_lru.sv ====
`timescale 1ns/1ps

module icache_lru
    import icache_geom_pkg::*, icache_ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    rstn,
    input  index_t  index,
    input  logic    touch,
    input  way_oh_t touch_way,
    output way_oh_t victim_way
);

    // Age 0 is the most recently used way, NUM_WAYS-1 the oldest.
    typedef logic [1:0] age_t;

    age_t age [NUM_SETS][NUM_WAYS];
    age_t touch_age;

    always_comb begin
        touch_age = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (touch_way[w]) begin
                touch_age = age[index][w];
            end
        end
    end

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            victim_way[w] = (age[index][w] == age_t'(NUM_WAYS - 1));
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    age[s][w] <= age_t'(w);
                end
            end
        end else if (touch) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (touch_way[w]) begin
                    age[index][w] <= '0;
                end else if (age[index][w] < touch_age) begin
                    age[index][w] <= age[index][w] + 1'b1;
                end
            end
        end
    end

endmodule

// ==== icache_main_fsm.sv ====
`timescale 1ns/1ps

module icache_main_fsm
    import icache_geom_pkg::*, icache_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rstn,
    input  logic              req_valid,
    input  addr_t             req_addr,
    input  logic              hit,
    input  logic              mem_req_ready,
    input  way_oh_t           victim_way,
    icache_fill_if.monitor    fill,
    output logic              req_ready,
    output addr_t             lookup_addr,
    output addr_t             miss_addr,
    output logic              refill_start,
    output way_oh_t           way_write,
    output logic              resp_sel_fill,
    output logic              resp_valid,
    output logic              lru_touch
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    addr_t       req_buf;
    addr_t       miss_buf;
    way_oh_t     miss_way;
    logic        lookup_hit;
    logic        fill_end;

    assign lookup_hit = (state == LOOKUP) && hit;
    assign fill_end   = (state == REFILL) && fill.fill_done;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // The request buffer follows the fetch port whenever a new request may be taken.
    always_ff @(posedge clk) begin
        if (req_ready) begin
            req_buf <= req_addr;
        end
    end

    // On a miss the victim is frozen here, since the LRU may move before the fill.
    always_ff @(posedge clk) begin
        if ((state == LOOKUP) && !hit) begin
            miss_buf <= req_buf;
            miss_way <= victim_way;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (req_valid) begin
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP: begin
                if (!hit) begin
                    state_nxt = REPLACE;
                end else if (!req_valid) begin
                    state_nxt = IDLE;
                end
            end
            REPLACE: begin
                if (mem_req_ready) begin
                    state_nxt = REFILL;
                end
            end
            REFILL: begin
                if (fill.fill_done) begin
                    state_nxt = req_valid ? LOOKUP : IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    assign req_ready     = (state == IDLE) || lookup_hit || fill_end;
    assign lookup_addr   = req_buf;
    assign miss_addr     = miss_buf;
    assign refill_start  = (state == REPLACE);
    assign way_write     = fill_end ? miss_way : '0;
    assign resp_sel_fill = (state == REFILL);
    assign resp_valid    = lookup_hit || fill_end;
    // Every response marks its way as most recently used.
    assign lru_touch     = lookup_hit || fill_end;

endmodule

// ==== icache_refill.sv ====
`timescale 1ns/1ps

module icache_refill
    import icache_geom_pkg::*;
(
    input  logic          clk,
    input  logic          rstn,
    input  logic          start,
    input  addr_t         miss_addr,
    input  logic          mem_req_ready,
    input  logic          mem_data_valid,
    input  word_t         mem_data,
    output logic          mem_req,
    output addr_t         mem_addr,
    output logic          mem_data_ready,
    icache_fill_if.source fill
);

    logic      busy;
    logic      beat;
    word_sel_t beat_cnt;
    line_t     line_buf;
    line_t     line_now;

    assign mem_req        = start && !busy;
    assign mem_addr       = {miss_addr[31:4], 4'b0000};
    assign mem_data_ready = busy;
    assign beat           = busy && mem_data_valid;

    // Beats are accepted only after the request has been taken.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy     <= 1'b0;
            beat_cnt <= '0;
        end else begin
            if (mem_req && mem_req_ready) begin
                busy <= 1'b1;
            end else if (fill.fill_done) begin
                busy <= 1'b0;
            end
            if (beat) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // The current beat is merged in so the line is complete on the last beat.
    always_comb begin
        line_now = line_buf;
        for (int i = 0; i < LINE_WORDS; i++) begin
            if (beat && (beat_cnt == word_sel_t'(i))) begin
                line_now[i*WORD_BITS +: WORD_BITS] = mem_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat) begin
            line_buf <= line_now;
        end
    end

    assign fill.fill_done  = beat && (beat_cnt == word_sel_t'(LINE_WORDS - 1));
    assign fill.fill_line  = line_now;
    assign fill.fill_index = addr_index(miss_addr);
    assign fill.fill_tag   = addr_tag(miss_addr);

endmodule

// ==== icache_top.sv ====
`timescale 1ns/1ps

module icache_top
    import icache_geom_pkg::*, icache_ctrl_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  logic  req_valid,
    input  addr_t req_addr,
    output logic  req_ready,
    output logic  resp_valid,
    output word_t resp_data,
    output logic  mem_req,
    output addr_t mem_addr,
    input  logic  mem_req_ready,
    input  logic  mem_data_valid,
    input  word_t mem_data,
    output logic  mem_data_ready
);

    logic    hit;
    way_oh_t hit_way;
    way_oh_t victim_way;
    way_oh_t way_write;
    addr_t   lookup_addr;
    addr_t   miss_addr;
    logic    refill_start;
    logic    resp_sel_fill;
    logic    lru_touch;

    icache_fill_if u_fill_if ();

    icache_main_fsm u_main_fsm (
        .clk           (clk),
        .rstn          (rstn),
        .req_valid     (req_valid),
        .req_addr      (req_addr),
        .hit           (hit),
        .mem_req_ready (mem_req_ready),
        .victim_way    (victim_way),
        .fill          (u_fill_if),
        .req_ready     (req_ready),
        .lookup_addr   (lookup_addr),
        .miss_addr     (miss_addr),
        .refill_start  (refill_start),
        .way_write     (way_write),
        .resp_sel_fill (resp_sel_fill),
        .resp_valid    (resp_valid),
        .lru_touch     (lru_touch)
    );

    icache_way_store u_way_store (
        .clk           (clk),
        .rstn          (rstn),
        .lookup_addr   (lookup_addr),
        .way_write     (way_write),
        .fill          (u_fill_if),
        .miss_word     (addr_word(miss_addr)),
        .resp_sel_fill (resp_sel_fill),
        .hit           (hit),
        .hit_way       (hit_way),
        .resp_data     (resp_data)
    );

    icache_lru u_lru (
        .clk        (clk),
        .rstn       (rstn),
        .index      (addr_index(lookup_addr)),
        .touch      (lru_touch),
        .touch_way  (hit_way),
        .victim_way (victim_way)
    );

    icache_refill u_refill (
        .clk            (clk),
        .rstn           (rstn),
        .start          (refill_start),
        .miss_addr      (miss_addr),
        .mem_req_ready  (mem_req_ready),
        .mem_data_valid (mem_data_valid),
        .mem_data       (mem_data),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .mem_data_ready (mem_data_ready),
        .fill           (u_fill_if)
    );

endmodule

// ==== icache_way_store.sv ====
`timescale 1ns/1ps

module icache_way_store
    import icache_geom_pkg::*, icache_ctrl_pkg::*;
(
    input  logic           clk,
    input  logic           rstn,
    input  addr_t          lookup_addr,
    input  way_oh_t        way_write,
    icache_fill_if.sink    fill,
    input  word_sel_t      miss_word,
    input  logic           resp_sel_fill,
    output logic           hit,
    output way_oh_t        hit_way,
    output word_t          resp_data
);

    tag_t                tag_mem  [NUM_WAYS][NUM_SETS];
    line_t               data_mem [NUM_WAYS][NUM_SETS];
    logic [NUM_SETS-1:0] valid    [NUM_WAYS];

    tag_t      lk_tag;
    index_t    lk_index;
    word_sel_t lk_word;
    way_oh_t   match;
    word_t     hit_word;

    assign lk_tag   = addr_tag(lookup_addr);
    assign lk_index = addr_index(lookup_addr);
    assign lk_word  = addr_word(lookup_addr);

    always_ff @(posedge clk) begin
        if (fill.fill_done) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (way_write[w]) begin
                    tag_mem[w][fill.fill_index]  <= fill.fill_tag;
                    data_mem[w][fill.fill_index] <= fill.fill_line;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                valid[w] <= '0;
            end
        end else if (fill.fill_done) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (way_write[w]) begin
                    valid[w][fill.fill_index] <= 1'b1;
                end
            end
        end
    end

    // All four tags of the set are compared at once.
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            match[w] = valid[w][lk_index] && (tag_mem[w][lk_index] == lk_tag);
        end
    end

    always_comb begin
        hit_word = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (match[w]) begin
                hit_word |= line_word(data_mem[w][lk_index], lk_word);
            end
        end
    end

    assign hit = |match;

    // During a fill the way being written is reported so the LRU can age it.
    assign hit_way = way_oh_any(way_write) ? way_write : match;

    // A fill answers straight from the incoming line, bypassing the arrays.
    assign resp_data = resp_sel_fill ? line_word(fill.fill_line, miss_word) : hit_word;

endmodule

// ==== tb_icache.sv ====
`timescale 1ns/1ps

module tb_icache;

    localparam int NUM_ENTRIES  = 20;
    localparam int ACCEPT_LIMIT = 200;
    localparam int DRAIN_LIMIT  = 400;

    logic        clk = 1'b0;
    logic        rstn = 1'b0;
    logic        req_valid = 1'b0;
    logic [31:0] req_addr = '0;
    logic        exp_hit = 1'b0;
    logic        req_ready;
    logic        resp_valid;
    logic [31:0] resp_data;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic        mem_req_ready = 1'b0;
    logic        mem_data_valid = 1'b0;
    logic [31:0] mem_data = '0;
    logic        mem_data_ready;

    int          resp_count;
    int          check_count;
    int          error_count;
    int          timeouts = 0;
    logic [31:0] tbl_addr [NUM_ENTRIES];
    logic        tbl_hit  [NUM_ENTRIES];
    int          mem_phase = 0;
    int          mem_wait = 0;
    int          beat_idx = 0;
    int          next_beat;
    logic [31:0] mem_line = '0;

    icache_top u_dut (
        .clk            (clk),
        .rstn           (rstn),
        .req_valid      (req_valid),
        .req_addr       (req_addr),
        .req_ready      (req_ready),
        .resp_valid     (resp_valid),
        .resp_data      (resp_data),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .mem_req_ready  (mem_req_ready),
        .mem_data_valid (mem_data_valid),
        .mem_data       (mem_data),
        .mem_data_ready (mem_data_ready)
    );

    tb_icache_checker u_checker (
        .clk            (clk),
        .rstn           (rstn),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req_addr       (req_addr),
        .exp_hit        (exp_hit),
        .resp_valid     (resp_valid),
        .resp_data      (resp_data),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .mem_req_ready  (mem_req_ready),
        .mem_data_valid (mem_data_valid),
        .mem_data_ready (mem_data_ready),
        .resp_count     (resp_count),
        .check_count    (check_count),
        .error_count    (error_count)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return (a >> 2) ^ 32'h5A5A_0000;
    endfunction

    task automatic set_entry(input int i, input logic [21:0] tag, input logic [5:0] idx,
                             input logic [1:0] word, input logic hit);
        tbl_addr[i] = {tag, idx, word, 2'b00};
        tbl_hit[i]  = hit;
    endtask

    task automatic load_table();
        // Cold miss, then hits streamed through two lines.
        set_entry(0,  22'h000001, 6'd1,  2'd2, 1'b0);
        set_entry(1,  22'h000001, 6'd1,  2'd2, 1'b1);
        set_entry(2,  22'h000001, 6'd1,  2'd0, 1'b1);
        set_entry(3,  22'h000001, 6'd1,  2'd3, 1'b1);
        set_entry(4,  22'h000001, 6'd1,  2'd1, 1'b1);
        set_entry(5,  22'h000002, 6'd2,  2'd1, 1'b0);
        set_entry(6,  22'h000002, 6'd2,  2'd3, 1'b1);
        set_entry(7,  22'h000001, 6'd1,  2'd2, 1'b1);
        set_entry(8,  22'h000002, 6'd2,  2'd0, 1'b1);
        // Five tags in set 5 push the first one out, which then evicts the second.
        set_entry(9,  22'h000010, 6'd5,  2'd0, 1'b0);
        set_entry(10, 22'h000011, 6'd5,  2'd1, 1'b0);
        set_entry(11, 22'h000012, 6'd5,  2'd2, 1'b0);
        set_entry(12, 22'h000013, 6'd5,  2'd3, 1'b0);
        set_entry(13, 22'h000014, 6'd5,  2'd0, 1'b0);
        set_entry(14, 22'h000010, 6'd5,  2'd1, 1'b0);
        set_entry(15, 22'h000011, 6'd5,  2'd2, 1'b0);
        set_entry(16, 22'h000014, 6'd5,  2'd3, 1'b1);
        set_entry(17, 22'h3FFFFF, 6'd63, 2'd3, 1'b0);
        set_entry(18, 22'h3FFFFF, 6'd63, 2'd0, 1'b1);
        set_entry(19, 22'h000001, 6'd1,  2'd1, 1'b1);
    endtask

    task automatic wait_accept(output bit ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < ACCEPT_LIMIT) begin
            @(posedge clk);
            ok = req_ready;
            n++;
        end
    endtask

    task automatic wait_responses(input int want, output bit ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < DRAIN_LIMIT) begin
            @(posedge clk);
            ok = (resp_count >= want);
            n++;
        end
    endtask

    // The memory waits a random 0 to 3 cycles before taking the request and
    // then sends four beats in order with random gaps between them.
    initial begin : mem_model
        void'($urandom(94));
        forever begin
            @(posedge clk);
            if (!rstn) begin
                mem_phase      <= 0;
                mem_req_ready  <= 1'b0;
                mem_data_valid <= 1'b0;
            end else if (mem_phase == 0) begin
                if (mem_req) begin
                    mem_wait  <= $urandom % 4;
                    mem_phase <= 1;
                end
            end else if (mem_phase == 1) begin
                if (mem_wait == 0) begin
                    mem_req_ready <= 1'b1;
                    mem_phase     <= 2;
                end else begin
                    mem_wait <= mem_wait - 1;
                end
            end else if (mem_phase == 2) begin
                if (mem_req && mem_req_ready) begin
                    mem_req_ready <= 1'b0;
                    mem_line      <= mem_addr;
                    beat_idx      <= 0;
                    mem_phase     <= 3;
                end
            end else begin
                next_beat = beat_idx;
                if (mem_data_valid && mem_data_ready) begin
                    next_beat = beat_idx + 1;
                end
                beat_idx <= next_beat;
                if (next_beat == 4) begin
                    mem_data_valid <= 1'b0;
                    mem_phase      <= 0;
                end else if (!mem_data_valid || mem_data_ready) begin
                    mem_data_valid <= (($urandom % 4) != 0);
                    mem_data       <= mem_word(mem_line + (next_beat << 2));
                end
            end
        end
    end

    initial begin : stimulus
        bit ok;
        load_table();
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);
        ok = 1'b1;
        // Each entry is driven on the edge where the previous one was taken.
        for (int i = 0; i < NUM_ENTRIES && ok; i++) begin
            req_valid <= 1'b1;
            req_addr  <= tbl_addr[i];
            exp_hit   <= tbl_hit[i];
            wait_accept(ok);
            if (!ok) begin
                timeouts++;
                $display("timeout: request %0d to %h was never accepted", i, tbl_addr[i]);
            end
        end
        req_valid <= 1'b0;
        if (ok) begin
            wait_responses(NUM_ENTRIES, ok);
            if (!ok) begin
                timeouts++;
                $display("timeout: only %0d of %0d responses arrived", resp_count, NUM_ENTRIES);
            end
        end
        repeat (4) @(posedge clk);
        $display("responses %0d of %0d, checks %0d, errors %0d, assertion failures %0d, %s%0d",
                 resp_count, NUM_ENTRIES, check_count, error_count,
                 u_dut.u_assert.fail_count, "timeouts ", timeouts);
        if (error_count == 0 && timeouts == 0 && resp_count == NUM_ENTRIES
            && u_dut.u_assert.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== tb_icache_assert.sv ====
`timescale 1ns/1ps

module tb_icache_assert (
    input logic        clk,
    input logic        rstn,
    input logic        req_valid,
    input logic        req_ready,
    input logic        resp_valid,
    input logic        mem_req,
    input logic [31:0] mem_addr,
    input logic        mem_req_ready,
    input logic        mem_data_ready
);

    int fail_count = 0;
    int open_reqs;

    // Accepted fetch requests that have not been answered yet.
    always @(posedge clk) begin
        if (!rstn) begin
            open_reqs <= 0;
        end else begin
            open_reqs <= open_reqs + int'(req_valid && req_ready) - int'(resp_valid);
        end
    end

    mem_req_held: assert property (@(posedge clk) disable iff (!rstn)
        mem_req && !mem_req_ready |=> mem_req && $stable(mem_addr))
        else begin
            fail_count++;
            $error("mem_req dropped or mem_addr changed before mem_req_ready");
        end

    resp_has_request: assert property (@(posedge clk) disable iff (!rstn)
        resp_valid |-> open_reqs > 0)
        else begin
            fail_count++;
            $error("resp_valid without an accepted request since the last response");
        end

    no_data_during_req: assert property (@(posedge clk) disable iff (!rstn)
        !(mem_data_ready && mem_req))
        else begin
            fail_count++;
            $error("mem_data_ready high while mem_req is high");
        end

endmodule

bind icache_top tb_icache_assert u_assert (
    .clk            (clk),
    .rstn           (rstn),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .resp_valid     (resp_valid),
    .mem_req        (mem_req),
    .mem_addr       (mem_addr),
    .mem_req_ready  (mem_req_ready),
    .mem_data_ready (mem_data_ready)
);

// ==== tb_icache_checker.sv ====
`timescale 1ns/1ps

module tb_icache_checker (
    input  logic        clk,
    input  logic        rstn,
    input  logic        req_valid,
    input  logic        req_ready,
    input  logic [31:0] req_addr,
    input  logic        exp_hit,
    input  logic        resp_valid,
    input  logic [31:0] resp_data,
    input  logic        mem_req,
    input  logic [31:0] mem_addr,
    input  logic        mem_req_ready,
    input  logic        mem_data_valid,
    input  logic        mem_data_ready,
    output int          resp_count,
    output int          check_count,
    output int          error_count
);

    logic [31:0] pend_addr [$];
    logic        pend_hit  [$];
    int          pend_cyc  [$];

    int          cyc = 0;
    int          n_resp = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          mem_reqs = 0;
    int          beats = 0;
    bit          in_reset = 1'b0;
    logic [31:0] addr;
    logic        want_hit;
    logic        got_hit;
    int          acc_cyc;
    logic [31:0] want_data;

    always @(posedge clk) begin
        cyc++;
        if (!rstn) begin
            in_reset = 1'b1;
            mem_reqs = 0;
            beats    = 0;
        end else begin
            if (in_reset) begin
                in_reset = 1'b0;
                n_checks++;
                if (!req_ready || mem_req || mem_data_ready || resp_valid) begin
                    n_errors++;
                    $display("mismatch at %0t: after reset req_ready=%b mem_req=%b %s%b %s%b",
                             $time, req_ready, mem_req, "mem_data_ready=", mem_data_ready,
                             "resp_valid=", resp_valid);
                end
            end
            if (mem_req && mem_req_ready) begin
                mem_reqs++;
                n_checks++;
                if (pend_addr.size() == 0) begin
                    n_errors++;
                    $display("error: memory request made while no fetch was outstanding");
                end else if (mem_addr != {pend_addr[0][31:4], 4'h0}) begin
                    n_errors++;
                    $display("mismatch at %0t: memory request to %h, expected line %h",
                             $time, mem_addr, {pend_addr[0][31:4], 4'h0});
                end
                if (mem_reqs > 1) begin
                    n_errors++;
                    $display("error: a second memory request was made for one miss");
                end
            end
            // The fourth beat lands on the same edge as the miss response.
            if (mem_data_valid && mem_data_ready) begin
                beats++;
            end
            if (resp_valid) begin
                n_resp++;
                if (pend_addr.size() == 0) begin
                    n_errors++;
                    $display("error: a response arrived with no outstanding request");
                end else begin
                    addr      = pend_addr.pop_front();
                    want_hit  = pend_hit.pop_front();
                    acc_cyc   = pend_cyc.pop_front();
                    got_hit   = (mem_reqs == 0);
                    want_data = (addr >> 2) ^ 32'h5A5A_0000;
                    n_checks += 2;
                    if (resp_data !== want_data) begin
                        n_errors++;
                        $display("mismatch at %0t: address %h returned %h, expected %h",
                                 $time, addr, resp_data, want_data);
                    end
                    if (got_hit != want_hit) begin
                        n_errors++;
                        $display("mismatch at %0t: address %h hit=%b, expected hit=%b",
                                 $time, addr, got_hit, want_hit);
                    end
                    if (got_hit && (cyc != acc_cyc + 1)) begin
                        n_errors++;
                        $display("mismatch at %0t: hit on %h answered after %0d cycles",
                                 $time, addr, cyc - acc_cyc);
                    end
                    if (!got_hit && (beats != 4)) begin
                        n_errors++;
                        $display("mismatch at %0t: miss on %h took %0d beats, expected 4",
                                 $time, addr, beats);
                    end
                    if (got_hit && req_valid && !req_ready) begin
                        n_errors++;
                        $display("error: a hit on %h did not take the next request", addr);
                    end
                end
                mem_reqs = 0;
                beats    = 0;
            end
            if (req_valid && req_ready) begin
                pend_addr.push_back(req_addr);
                pend_hit.push_back(exp_hit);
                pend_cyc.push_back(cyc);
            end
        end
        resp_count  <= n_resp;
        check_count <= n_checks;
        error_count <= n_errors;
    end

endmodule
